/* source/fetch_pkg.sv */
/*
  fetch-side constants and the structs on the memory, queue and issue paths.
  RV32 only; a fetch word holds two 16-bit parcels, parcel 0 being the lower one.
*/
package fetch_pkg;

  localparam int unsigned INFLIGHT_MAX     = 2;  // words the memory may still owe us
  localparam int unsigned PARCELS_PER_WORD = 2;

  typedef logic [15:0] parcel_t;

  // queue fill level, so queue depth is limited to 255 parcels
  typedef logic [7:0] queue_cnt_t;

  typedef struct packed {
    parcel_t [PARCELS_PER_WORD-1:0] parcel;
    logic    [PARCELS_PER_WORD-1:0] valid;  // 2'b10 for a fetch from an odd halfword
    logic                           err;    // access fault on this word
  } fetch_rsp_t;

  typedef struct packed {
    parcel_t parcel;
    logic    err;
  } queue_entry_t;

  typedef struct packed {
    logic [31:0] instr;         // expanded when it came from a compressed parcel
    logic [31:0] pc;
    logic        illegal;
    logic        access_fault;
  } fetched_insn_t;

endpackage

/* source/rv_isa_pkg.sv */
/*
  RV32 encodings used by the fetch stage: major opcodes, the compressed
  opcodes that the expander knows, and encoders for the base formats.
  Only the compressed subset listed in rvc_op_e is recognized.
*/
package rv_isa_pkg;

  typedef logic [4:0]  reg_idx_t;
  typedef logic [31:0] instr_t;

  typedef enum logic [6:0] {
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    OP     = 7'b0110011,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    BRANCH = 7'b1100011,
    SYSTEM = 7'b1110011
  } opcode_e;

  // key is {quadrant, funct3, bit 12}; bit 12 only counts in quadrant 2
  typedef enum logic [5:0] {
    ADDI4SPN     = 6'b00_000_0,
    LW           = 6'b00_010_0,
    SW           = 6'b00_110_0,
    ADDI         = 6'b01_000_0,
    JAL_RV32     = 6'b01_001_0,
    LI           = 6'b01_010_0,
    LUI_ADDI16SP = 6'b01_011_0,
    J            = 6'b01_101_0,
    BEQZ         = 6'b01_110_0,
    BNEZ         = 6'b01_111_0,
    JR_MV        = 6'b10_100_0,
    JALR_ADD     = 6'b10_100_1
  } rvc_op_e;

  localparam instr_t NOP_INSN    = {12'h000, 5'd0, 3'b000, 5'd0, OP_IMM};  // addi x0,x0,0
  localparam instr_t EBREAK_INSN = {12'h001, 5'd0, 3'b000, 5'd0, SYSTEM};

  //////////////////////////////////////////////////
  // format encoders

  function automatic instr_t encode_r(opcode_e opc, logic [2:0] f3, logic [6:0] f7,
                                      reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic instr_t encode_i(opcode_e opc, logic [2:0] f3, reg_idx_t rd,
                                      reg_idx_t rs1, logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic instr_t encode_s(opcode_e opc, logic [2:0] f3, reg_idx_t rs1,
                                      reg_idx_t rs2, logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], opc};
  endfunction

  // imm[0] is dropped, branch offsets are even
  function automatic instr_t encode_b(opcode_e opc, logic [2:0] f3, reg_idx_t rs1,
                                      reg_idx_t rs2, logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc};
  endfunction

  function automatic instr_t encode_u(opcode_e opc, reg_idx_t rd, logic [19:0] imm);
    return {imm, rd, opc};
  endfunction

  function automatic instr_t encode_j(opcode_e opc, reg_idx_t rd, logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc};
  endfunction

endpackage

/* source/fetch_addr_gen.sv */
/*
  fetch address counter. Requests are word aligned after the first one;
  a redirect may point at an odd halfword and then fetches that word.
*/
`timescale 1ns/1ps

module fetch_addr_gen
  import fetch_pkg::*;
#(
  parameter logic [31:0] PC_INIT = 32'h0000_0200
)
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        almost_full_i,
  input  logic        redirect_i,
  input  logic [31:0] redirect_pc_i,
  input  logic        mem_ack_i,
  output logic        mem_req_o,
  output logic [31:0] mem_adr_o,
  output logic        mem_flush_o
);

  localparam int unsigned WORD_BYTES = PARCELS_PER_WORD * 2;
  localparam logic [31:0] WORD_MASK  = ~(32'(WORD_BYTES) - 32'd1);

  logic [31:0] adr_q;
  logic        accepted;

  // no new fetch while the queue is filling up or the stream is being restarted
  assign mem_req_o   = ~almost_full_i & ~redirect_i;
  assign mem_flush_o = redirect_i;                  // memory drops what it still owes
  assign accepted    = mem_req_o & mem_ack_i;
  assign mem_adr_o   = adr_q;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      adr_q <= PC_INIT;
    else if (redirect_i)
      adr_q <= {redirect_pc_i[31:1], 1'b0};         // halfword aligned target
    else if (accepted)
      adr_q <= (adr_q + 32'(WORD_BYTES)) & WORD_MASK;  // next word boundary
  end

endmodule

/* source/parcel_queue.sv */
/*
  parcel FIFO, two parcels in and up to two out per cycle. No overflow check;
  the memory must owe at most INFLIGHT_MAX words when a request is accepted.
  DEPTH is at least PARCELS_PER_WORD*(INFLIGHT_MAX+1) and below 256.
*/
`timescale 1ns/1ps

module parcel_queue
  import fetch_pkg::*;
#(
  parameter int unsigned DEPTH = 12
)
(
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               flush_i,
  input  logic               rsp_valid_i,
  input  fetch_rsp_t         rsp_i,
  input  logic [1:0]         pop_i,
  output queue_entry_t [1:0] head_o,
  output queue_cnt_t         count_o,
  output logic               almost_full_o
);

  localparam int unsigned PW       = $clog2(DEPTH);
  // room must stay for the words still in flight plus the one being written
  localparam int unsigned AF_LEVEL = DEPTH - PARCELS_PER_WORD * (INFLIGHT_MAX + 1);

  queue_entry_t  mem_q [DEPTH];
  logic [PW-1:0] rd_ptr_q;
  logic [PW-1:0] wr_ptr_q;
  queue_cnt_t    count_q;
  logic [1:0]    wr_en;
  logic [1:0]    n_wr;
  queue_entry_t  wr_lo;
  queue_entry_t  wr_hi;

  // circular pointer step, DEPTH need not be a power of two
  function automatic logic [PW-1:0] ptr_add(logic [PW-1:0] ptr, logic [1:0] inc);
    logic [PW:0] sum;
    sum = (PW+1)'(ptr) + (PW+1)'(inc);
    if (sum >= (PW+1)'(DEPTH))
      sum = sum - (PW+1)'(DEPTH);
    return sum[PW-1:0];
  endfunction

  //////////////////////////////////////////////////
  // write side

  // valid parcels are packed into consecutive slots
  assign wr_en[0] = rsp_valid_i & ~flush_i & (|rsp_i.valid);
  assign wr_en[1] = rsp_valid_i & ~flush_i & (&rsp_i.valid);
  assign n_wr     = {1'b0, wr_en[0]} + {1'b0, wr_en[1]};

  always_comb
  begin
    wr_lo.parcel = rsp_i.valid[0] ? rsp_i.parcel[0] : rsp_i.parcel[1];
    wr_lo.err    = rsp_i.err;
    wr_hi.parcel = rsp_i.parcel[1];
    wr_hi.err    = rsp_i.err;
  end

  always_ff @(posedge clk_i)
  begin
    if (wr_en[0])
      mem_q[wr_ptr_q] <= wr_lo;
    if (wr_en[1])
      mem_q[ptr_add(wr_ptr_q, 2'd1)] <= wr_hi;
  end

  //////////////////////////////////////////////////
  // pointers and fill level

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end
    else if (flush_i)
    begin
      rd_ptr_q <= '0;   // contents discarded
      wr_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      rd_ptr_q <= ptr_add(rd_ptr_q, pop_i);
      wr_ptr_q <= ptr_add(wr_ptr_q, n_wr);
      count_q  <= count_q + queue_cnt_t'(n_wr) - queue_cnt_t'(pop_i);
    end
  end

  assign head_o[0]     = mem_q[rd_ptr_q];
  assign head_o[1]     = mem_q[ptr_add(rd_ptr_q, 2'd1)];
  assign count_o       = count_q;
  assign almost_full_o = count_q > queue_cnt_t'(AF_LEVEL);

endmodule

/* source/rvc_expander.sv */
/*
  compressed to 32-bit expansion, purely combinational. Knows the RV32
  integer subset only; anything else comes out illegal and zero-extended.
*/
`timescale 1ns/1ps

module rvc_expander
  import fetch_pkg::*, rv_isa_pkg::*;
#(
  parameter bit HAS_RVC = 1'b1
)
(
  input  parcel_t parcel_i,
  output instr_t  instr_o,
  output logic    illegal_o
);

  localparam reg_idx_t X0 = 5'd0;
  localparam reg_idx_t X1 = 5'd1;   // link register
  localparam reg_idx_t X2 = 5'd2;   // stack pointer

  logic [5:0]  op_key;
  reg_idx_t    rd_full;
  reg_idx_t    rs2_full;
  reg_idx_t    rd_prime;
  reg_idx_t    rs1_prime;
  logic [5:0]  ci_bits;
  logic [11:0] imm_ci;
  logic [11:0] imm_ciw;
  logic [11:0] imm_cl;
  logic [11:0] imm_16sp;
  logic [19:0] imm_lui;
  logic [20:0] imm_cj;
  logic [12:0] imm_cb;
  instr_t      expanded;
  logic        bad;

  assign op_key = {parcel_i[1:0], parcel_i[15:13], (parcel_i[1:0] == 2'b10) & parcel_i[12]};

  // register fields; the 3-bit forms name x8..x15
  assign rd_full   = parcel_i[11:7];
  assign rs2_full  = parcel_i[6:2];
  assign rd_prime  = {2'b01, parcel_i[4:2]};
  assign rs1_prime = {2'b01, parcel_i[9:7]};

  //////////////////////////////////////////////////
  // immediates, scattered per format

  assign ci_bits  = {parcel_i[12], parcel_i[6:2]};
  assign imm_ci   = {{6{parcel_i[12]}}, ci_bits};
  assign imm_ciw  = {2'b00, parcel_i[10:7], parcel_i[12:11], parcel_i[5], parcel_i[6], 2'b00};
  assign imm_cl   = {5'b0, parcel_i[5], parcel_i[12:10], parcel_i[6], 2'b00};  // word offset
  assign imm_16sp = {{3{parcel_i[12]}}, parcel_i[4:3], parcel_i[5], parcel_i[2],
                     parcel_i[6], 4'b0000};
  assign imm_lui  = {{14{parcel_i[12]}}, ci_bits};
  assign imm_cj   = {{10{parcel_i[12]}}, parcel_i[8], parcel_i[10:9], parcel_i[6],
                     parcel_i[7], parcel_i[2], parcel_i[11], parcel_i[5:3], 1'b0};
  assign imm_cb   = {{5{parcel_i[12]}}, parcel_i[6:5], parcel_i[2], parcel_i[11:10],
                     parcel_i[4:3], 1'b0};

  always_comb
  begin
    expanded = NOP_INSN;
    bad      = 1'b0;
    case (rvc_op_e'(op_key))
      ADDI4SPN:
      begin
        bad      = (parcel_i == '0);   // all zeros is defined illegal
        expanded = encode_i(OP_IMM, 3'b000, rd_prime, X2, imm_ciw);
      end
      LW:       expanded = encode_i(LOAD, 3'b010, rd_prime, rs1_prime, imm_cl);
      SW:       expanded = encode_s(STORE, 3'b010, rs1_prime, rd_prime, imm_cl);
      ADDI:     expanded = (rd_full == X0) ? NOP_INSN
                                           : encode_i(OP_IMM, 3'b000, rd_full, rd_full, imm_ci);
      JAL_RV32: expanded = encode_j(JAL, X1, imm_cj);
      LI:       expanded = encode_i(OP_IMM, 3'b000, rd_full, X0, imm_ci);
      LUI_ADDI16SP:
      begin
        bad      = (ci_bits == '0);    // reserved in both forms
        expanded = (rd_full == X2) ? encode_i(OP_IMM, 3'b000, X2, X2, imm_16sp)
                                   : encode_u(LUI, rd_full, imm_lui);
      end
      J:        expanded = encode_j(JAL, X0, imm_cj);
      BEQZ:     expanded = encode_b(BRANCH, 3'b000, rs1_prime, X0, imm_cb);
      BNEZ:     expanded = encode_b(BRANCH, 3'b001, rs1_prime, X0, imm_cb);
      JR_MV:
      begin
        if (rs2_full != X0)
          expanded = encode_r(OP, 3'b000, 7'b0000000, rd_full, X0, rs2_full);  // c.mv
        else
        begin
          bad      = (rd_full == X0);
          expanded = encode_i(JALR, 3'b000, X0, rd_full, 12'h000);           // c.jr
        end
      end
      JALR_ADD:
      begin
        if (rs2_full != X0)
          expanded = encode_r(OP, 3'b000, 7'b0000000, rd_full, rd_full, rs2_full);
        else if (rd_full != X0)
          expanded = encode_i(JALR, 3'b000, X1, rd_full, 12'h000);
        else
          expanded = EBREAK_INSN;
      end
      default:  bad = 1'b1;
    endcase
  end

  // without RVC support every parcel is illegal
  assign illegal_o = bad | !HAS_RVC;
  assign instr_o   = illegal_o ? {16'h0000, parcel_i} : expanded;

endmodule

/* source/insn_issue.sv */
/*
  issue stage: takes one 16- or 32-bit instruction per cycle from the queue
  head and registers it with its PC. stall_i holds the output and pops nothing.
*/
`timescale 1ns/1ps

module insn_issue
  import fetch_pkg::*, rv_isa_pkg::*;
#(
  parameter logic [31:0] PC_INIT = 32'h0000_0200,
  parameter bit          HAS_RVC = 1'b1
)
(
  input  logic               clk_i,
  input  logic               rst_ni,
  input  queue_entry_t [1:0] head_i,
  input  queue_cnt_t         count_i,
  output logic [1:0]         pop_o,
  input  logic               redirect_i,
  input  logic [31:0]        redirect_pc_i,
  input  logic               stall_i,
  output logic               insn_valid_o,
  output fetched_insn_t      insn_o
);

  logic          is_32bit;
  logic          avail;
  logic          issue;
  instr_t        rvc_instr;
  logic          rvc_illegal;
  logic [31:0]   next_pc_q;
  logic          valid_q;
  fetched_insn_t insn_d;
  fetched_insn_t insn_q;

  rvc_expander #(
    .HAS_RVC ( HAS_RVC )
  ) u_rvc_expander (
    .parcel_i  ( head_i[0].parcel ),
    .instr_o   ( rvc_instr        ),
    .illegal_o ( rvc_illegal      )
  );

  // low bits 11 mark a 32-bit instruction, which needs both head parcels
  assign is_32bit = &head_i[0].parcel[1:0];
  assign avail    = is_32bit ? (count_i >= queue_cnt_t'(2)) : (count_i >= queue_cnt_t'(1));
  assign issue    = avail & ~stall_i & ~redirect_i;
  assign pop_o    = !issue ? 2'd0 : (is_32bit ? 2'd2 : 2'd1);

  always_comb
  begin
    insn_d.pc = next_pc_q;
    if (is_32bit)
    begin
      insn_d.instr        = {head_i[1].parcel, head_i[0].parcel};
      insn_d.illegal      = 1'b0;
      insn_d.access_fault = head_i[0].err | head_i[1].err;
    end
    else
    begin
      insn_d.instr        = rvc_instr;
      insn_d.illegal      = rvc_illegal;
      insn_d.access_fault = head_i[0].err;
    end
  end

  //////////////////////////////////////////////////
  // program counter and output register

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      next_pc_q <= PC_INIT;
    else if (redirect_i)
      next_pc_q <= redirect_pc_i;
    else if (issue)
      next_pc_q <= next_pc_q + (is_32bit ? 32'd4 : 32'd2);
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      valid_q <= 1'b0;
    else if (redirect_i)
      valid_q <= 1'b0;       // bubble after a redirect
    else if (!stall_i)
      valid_q <= issue;
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      insn_q <= '0;
    else if (issue)
      insn_q <= insn_d;
  end

  assign insn_valid_o = valid_q;
  assign insn_o       = insn_q;

endmodule

/* source/instr_fetch_top.sv */
/*
  instruction fetch top level. The memory answers in order and owes at most
  INFLIGHT_MAX words when it accepts a request; responses to requests
  accepted up to a flush cycle are dropped by the memory.
*/
`timescale 1ns/1ps

module instr_fetch_top
  import fetch_pkg::*;
#(
  parameter logic [31:0] PC_INIT     = 32'h0000_0200,
  parameter int unsigned QUEUE_DEPTH = 12,
  parameter bit          HAS_RVC     = 1'b1
)
(
  input  logic          clk_i,
  input  logic          rst_ni,
  output logic          mem_req_o,
  output logic [31:0]   mem_adr_o,
  input  logic          mem_ack_i,
  input  logic          mem_rsp_valid_i,
  input  fetch_rsp_t    mem_rsp_i,
  output logic          mem_flush_o,
  input  logic          redirect_i,
  input  logic [31:0]   redirect_pc_i,
  input  logic          stall_i,
  output logic          insn_valid_o,
  output fetched_insn_t insn_o
);

  logic               almost_full;
  queue_entry_t [1:0] head;
  queue_cnt_t         count;
  logic [1:0]         pop;

  fetch_addr_gen #(
    .PC_INIT ( PC_INIT )
  ) u_fetch_addr_gen (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .almost_full_i ( almost_full   ),
    .redirect_i    ( redirect_i    ),
    .redirect_pc_i ( redirect_pc_i ),
    .mem_ack_i     ( mem_ack_i     ),
    .mem_req_o     ( mem_req_o     ),
    .mem_adr_o     ( mem_adr_o     ),
    .mem_flush_o   ( mem_flush_o   )
  );

  parcel_queue #(
    .DEPTH ( QUEUE_DEPTH )
  ) u_parcel_queue (
    .clk_i         ( clk_i           ),
    .rst_ni        ( rst_ni          ),
    .flush_i       ( redirect_i      ),
    .rsp_valid_i   ( mem_rsp_valid_i ),
    .rsp_i         ( mem_rsp_i       ),
    .pop_i         ( pop             ),
    .head_o        ( head            ),
    .count_o       ( count           ),
    .almost_full_o ( almost_full     )
  );

  insn_issue #(
    .PC_INIT ( PC_INIT ),
    .HAS_RVC ( HAS_RVC )
  ) u_insn_issue (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .head_i        ( head          ),
    .count_i       ( count         ),
    .pop_o         ( pop           ),
    .redirect_i    ( redirect_i    ),
    .redirect_pc_i ( redirect_pc_i ),
    .stall_i       ( stall_i       ),
    .insn_valid_o  ( insn_valid_o  ),
    .insn_o        ( insn_o        )
  );

endmodule

/* dv/instr_fetch_properties.sv */
/*
  protocol rules on the fetch top-level ports, bound into instr_fetch_top.
  Checks stay off while rst_ni is low.
*/
`timescale 1ns/1ps

module instr_fetch_properties
  import fetch_pkg::*;
(
  input logic          clk_i,
  input logic          rst_ni,
  input logic          redirect_i,
  input logic          mem_req_o,
  input logic          stall_i,
  input logic          insn_valid_o,
  input fetched_insn_t insn_o
);

  // no fetch goes out while the stream restarts
  no_req_on_redirect: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
      !(redirect_i && mem_req_o))
    else $error("mem_req_o high during redirect_i");

  // stall freezes the output, a redirect may still clear it
  hold_on_stall: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
      (stall_i && !redirect_i) |=> ($stable(insn_o) && $stable(insn_valid_o)))
    else $error("insn output changed under stall_i");

  bubble_after_redirect: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
      redirect_i |=> !insn_valid_o)
    else $error("insn_valid_o high right after redirect_i");

endmodule

bind instr_fetch_top instr_fetch_properties u_props (
  .clk_i        ( clk_i        ),
  .rst_ni       ( rst_ni       ),
  .redirect_i   ( redirect_i   ),
  .mem_req_o    ( mem_req_o    ),
  .stall_i      ( stall_i      ),
  .insn_valid_o ( insn_valid_o ),
  .insn_o       ( insn_o       )
);

/* dv/tb_instr_fetch.sv */
/*
  directed testbench for instr_fetch_top. The memory model covers 1 KB,
  answers in order 1 to 3 cycles after an ack and owes at most INFLIGHT_MAX
  words. Expected values come from the image and the RISC-V encodings.
*/
`timescale 1ns/1ps

module tb_instr_fetch;
  import fetch_pkg::*;

  localparam time CLK_PERIOD   = 20ns;
  localparam int  TEST_LEN_SUM = 74;   // issued instructions over all tests
  localparam int  WAIT_LIMIT   = 200;  // cycles per instruction

  logic          clk;
  logic          rst_n;
  logic          mem_req;
  logic [31:0]   mem_adr;
  logic          mem_ack;
  logic          mem_rsp_valid;
  fetch_rsp_t    mem_rsp;
  logic          mem_flush;
  logic          redirect;
  logic [31:0]   redirect_pc;
  logic          stall;
  logic          insn_valid;
  fetched_insn_t insn;

  logic [31:0]   img [256];          // memory image with one entry per word
  logic [15:0]   lfsr_q = 16'd79;
  logic          stall_en;
  logic          err_en;
  logic [31:0]   err_adr;
  logic [31:0]   pend_adr [$];
  int            pend_rdy [$];
  int            cyc;
  logic [31:0]   build_pc;
  fetched_insn_t exp_q [$];

  instr_fetch_top #(
    .PC_INIT     ( 32'h0000_0200 ),
    .QUEUE_DEPTH ( 12            ),
    .HAS_RVC     ( 1'b1          )
  ) uut (
    .clk_i           ( clk           ),
    .rst_ni          ( rst_n         ),
    .mem_req_o       ( mem_req       ),
    .mem_adr_o       ( mem_adr       ),
    .mem_ack_i       ( mem_ack       ),
    .mem_rsp_valid_i ( mem_rsp_valid ),
    .mem_rsp_i       ( mem_rsp       ),
    .mem_flush_o     ( mem_flush     ),
    .redirect_i      ( redirect      ),
    .redirect_pc_i   ( redirect_pc   ),
    .stall_i         ( stall         ),
    .insn_valid_o    ( insn_valid    ),
    .insn_o          ( insn          )
  );

  always #(CLK_PERIOD/2) clk = ~clk;

  //////////////////////////////////////////////////
  // helpers

  // taps 16,14,13,11
  function automatic logic rand_bit();
    logic fb;
    fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
    lfsr_q = {lfsr_q[14:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
      v = {v[30:0], rand_bit()};
    return v;
  endfunction

  function automatic logic [15:0] parcel_at(logic [31:0] a);
    return a[1] ? img[a[9:2]][31:16] : img[a[9:2]][15:0];
  endfunction

  function automatic logic err_of(logic [31:0] a);
    return err_en && (a[31:2] == err_adr[31:2]);
  endfunction

  task automatic set_parcel(logic [31:0] a, logic [15:0] p);
    if (a[1])
      img[a[9:2]][31:16] = p;
    else
      img[a[9:2]][15:0] = p;
  endtask

  task automatic stop_on_error(string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp)
      stop_on_error($sformatf("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp));
  endtask

  //////////////////////////////////////////////////
  // memory model

  function automatic fetch_rsp_t make_rsp(logic [31:0] a);
    fetch_rsp_t r;
    r.parcel[0] = img[a[9:2]][15:0];
    r.parcel[1] = img[a[9:2]][31:16];
    r.valid     = a[1] ? 2'b10 : 2'b11;  // odd halfword start
    r.err       = err_of(a);
    return r;
  endfunction

  always
  begin
    logic [31:0] a;
    @(posedge clk);
    #2;
    cyc++;
    mem_rsp_valid = 1'b0;
    mem_rsp       = '0;
    if (pend_adr.size() > 0 && pend_rdy[0] <= cyc)
    begin
      a = pend_adr.pop_front();
      void'(pend_rdy.pop_front());
      mem_rsp_valid = 1'b1;
      mem_rsp       = make_rsp(a);
    end
    // ack only while fewer than INFLIGHT_MAX words are owed
    mem_ack = rand_bit() & ((pend_adr.size() + int'(mem_rsp_valid)) < INFLIGHT_MAX);
    stall   = stall_en & rand_bit();
  end

  always @(negedge clk)
  begin
    if (mem_flush)
    begin
      pend_adr.delete();
      pend_rdy.delete();
    end
    else if (rst_n && mem_req && mem_ack)
    begin
      pend_adr.push_back(mem_adr);
      pend_rdy.push_back(cyc + 1 + int'(rand_bits(2) % 3));
    end
  end

  //////////////////////////////////////////////////
  // stream building and checking

  task automatic add_c(logic [15:0] p, logic [31:0] exp, logic ill);
    set_parcel(build_pc, p);
    exp_q.push_back('{instr: exp, pc: build_pc, illegal: ill, access_fault: 1'b0});
    build_pc += 2;
  endtask

  task automatic add_w(logic [31:0] w);
    set_parcel(build_pc, w[15:0]);
    set_parcel(build_pc + 2, w[31:16]);
    exp_q.push_back('{instr: w, pc: build_pc, illegal: 1'b0, access_fault: 1'b0});
    build_pc += 4;
  endtask

  // 32-bit instructions read parcel by parcel straight from the image
  task automatic expect_words(logic [31:0] pc, int n);
    for (int i = 0; i < n; i++)
    begin
      exp_q.push_back('{instr: {parcel_at(pc + 2), parcel_at(pc)}, pc: pc, illegal: 1'b0,
                        access_fault: err_of(pc) | err_of(pc + 2)});
      pc += 4;
    end
  endtask

  task automatic fill_words(logic [31:0] base, int n);
    for (int i = 0; i < n; i++)
      img[base[9:2] + i] = (rand_bits(30) << 2) | 32'h0000_0003;
  endtask

  task automatic redirect_to(logic [31:0] pc);
    @(posedge clk);
    #2;
    redirect    = 1'b1;
    redirect_pc = pc;
    @(posedge clk);
    #2;
    redirect    = 1'b0;
  endtask

  task automatic wait_insn(output fetched_insn_t got);
    int n;
    n = 0;
    do
    begin
      @(negedge clk);
      n++;
      if (n > WAIT_LIMIT)
        stop_on_error("no instruction was issued within the wait limit");
    end
    while (!(insn_valid && !stall));
    got = insn;
  endtask

  task automatic check_stream();
    fetched_insn_t got;
    fetched_insn_t e;
    while (exp_q.size() > 0)
    begin
      e = exp_q.pop_front();
      wait_insn(got);
      check("insn_o.pc", got.pc, e.pc);
      check("insn_o.instr", got.instr, e.instr);
      check("insn_o.illegal", 32'(got.illegal), 32'(e.illegal));
      check("insn_o.access_fault", 32'(got.access_fault), 32'(e.access_fault));
    end
  endtask

  //////////////////////////////////////////////////
  // directed tests

  task automatic test_seq32();
    fill_words(32'h100, 16);
    expect_words(32'h100, 16);
    redirect_to(32'h100);
    check_stream();
  endtask

  task automatic test_stall();
    fill_words(32'h180, 16);
    expect_words(32'h180, 16);
    stall_en = 1'b1;
    redirect_to(32'h180);
    check_stream();
    stall_en = 1'b0;
  endtask

  task automatic test_rvc();
    build_pc = 32'h200;
    add_c(16'h0040, 32'h0041_0413, 1'b0);  // c.addi4spn x8,4
    add_c(16'h4144, 32'h0045_2483, 1'b0);  // c.lw x9,4(x10)
    add_w(32'h00A0_0093);
    add_c(16'hC504, 32'h0095_2423, 1'b0);  // c.sw x9,8(x10)
    add_c(16'h12FD, 32'hFFF2_8293, 1'b0);
    add_c(16'h0001, 32'h0000_0013, 1'b0);  // c.nop
    add_c(16'h2009, 32'h0020_00EF, 1'b0);  // c.jal 2
    add_c(16'h4315, 32'h0050_0313, 1'b0);
    add_c(16'h6385, 32'h0000_13B7, 1'b0);  // c.lui x7,1
    add_c(16'h6141, 32'h0101_0113, 1'b0);  // c.addi16sp 16
    add_w(32'h0041_8193);
    add_c(16'hBFFD, 32'hFFFF_F06F, 1'b0);  // c.j -2
    add_c(16'hC011, 32'h0004_0263, 1'b0);
    add_c(16'hE091, 32'h0004_9263, 1'b0);  // c.bnez x9,4
    add_c(16'h852E, 32'h00B0_0533, 1'b0);  // c.mv x10,x11
    add_c(16'h8082, 32'h0000_8067, 1'b0);
    add_c(16'h952E, 32'h00B5_0533, 1'b0);  // c.add x10,x11
    add_c(16'h9282, 32'h0002_80E7, 1'b0);  // c.jalr x5
    add_c(16'h9002, 32'h0010_0073, 1'b0);  // c.ebreak
    redirect_to(32'h200);
    check_stream();
  endtask

  task automatic test_illegal();
    build_pc = 32'h280;
    add_c(16'h0000, 32'h0000_0000, 1'b1);
    add_c(16'h8002, 32'h0000_8002, 1'b1);  // c.jr x0
    add_c(16'h6381, 32'h0000_6381, 1'b1);  // c.lui zero imm
    add_c(16'h4082, 32'h0000_4082, 1'b1);  // c.lwsp is not kept
    redirect_to(32'h280);
    check_stream();
  endtask

  task automatic test_redirect();
    fill_words(32'h300, 8);
    expect_words(32'h300, 3);
    redirect_to(32'h300);
    check_stream();
    // new target mid-stream with the first instruction in an upper parcel
    for (int k = 0; k < 16; k++)
      set_parcel(32'h342 + 2*k, (k % 2 == 0) ? 16'((rand_bits(14) << 2) | 32'h3)
                                             : 16'(rand_bits(16)));
    expect_words(32'h342, 8);
    redirect_to(32'h342);
    check_stream();
  endtask

  task automatic test_fault();
    fill_words(32'h380, 8);
    err_adr = 32'h38C;
    err_en  = 1'b1;
    expect_words(32'h380, 8);
    redirect_to(32'h380);
    check_stream();
    err_en  = 1'b0;
  endtask

  initial
  begin
    #(TEST_LEN_SUM * 40 * CLK_PERIOD);
    stop_on_error("timeout, the tests did not finish in time");
  end

  initial
  begin
    clk           = 1'b0;
    rst_n         = 1'b0;
    mem_ack       = 1'b0;
    mem_rsp_valid = 1'b0;
    mem_rsp       = '0;
    redirect      = 1'b0;
    redirect_pc   = '0;
    stall         = 1'b0;
    stall_en      = 1'b0;
    err_en        = 1'b0;
    err_adr       = '0;
    cyc           = 0;
    for (int i = 0; i < 256; i++)
      img[i] = {i[7:0], ~i[7:0], i[7:0], 8'h13};  // addi-like fill
    repeat (2) @(posedge clk);
    #2;
    rst_n = 1'b1;
    test_seq32();
    test_rvc();
    test_illegal();
    test_redirect();
    test_stall();
    test_fault();
    $display("Testbench passed");
    $finish;
  end

endmodule

/* project.f */
source/fetch_pkg.sv
source/rv_isa_pkg.sv
source/fetch_addr_gen.sv
source/parcel_queue.sv
source/rvc_expander.sv
source/insn_issue.sv
source/instr_fetch_top.sv
dv/instr_fetch_properties.sv
dv/tb_instr_fetch.sv

/* Bender.yml */
package:
  name: instr_fetch

sources:
  - source/fetch_pkg.sv
  - source/rv_isa_pkg.sv
  - source/fetch_addr_gen.sv
  - source/parcel_queue.sv
  - source/rvc_expander.sv
  - source/insn_issue.sv
  - source/instr_fetch_top.sv
  - target: test
    files:
      - dv/instr_fetch_properties.sv
      - dv/tb_instr_fetch.sv
